// ==== build.f ====
common/scope_pkg.sv
rtl/scope_regs.sv
rtl/stream_combiner.sv
rtl/frame_marker.sv
rtl/trigger_hub.sv
dma/dma_writer.sv
rtl/scope_capture.sv
test/scope_capture_props.sv
test/scope_capture_tb.sv

// ==== common/scope_pkg.sv ====
// Scope capture package holding the register map and the shared bus widths
package scope_pkg;

    // APB address and memory byte address width
    localparam int ADDR_WIDTH = 32;

    // Width of every configuration and status register
    localparam int REG_WIDTH = 32;

    // Sample counter within a frame, also the width of the trigger position
    localparam int FRAME_COUNT_WIDTH = 16;

    // Number of samples in one frame
    localparam logic [ADDR_WIDTH-1:0] REG_FRAME_LEN = 32'h00;

    // Bit 0 enables the DMA writer
    localparam logic [ADDR_WIDTH-1:0] REG_ENABLE = 32'h04;

    // Byte address of the first memory word of a frame
    localparam logic [ADDR_WIDTH-1:0] REG_BASE_ADDR = 32'h08;

    // Trigger line index; a write here also arms the hub
    localparam logic [ADDR_WIDTH-1:0] REG_TRIGGER_SEL = 32'h0C;

    // Writing bit 0 as 1 releases the capture inhibit
    localparam logic [ADDR_WIDTH-1:0] REG_CAPTURE_ACK = 32'h10;

    // Sample index inside the frame where the trigger fires
    localparam logic [ADDR_WIDTH-1:0] REG_TRIGGER_POS = 32'h14;

    // Read only status with count, inhibit and armed flags
    localparam logic [ADDR_WIDTH-1:0] REG_STATUS = 32'h18;

endpackage

// ==== dma/dma_writer.sv ====
// DMA writer turning the framed stream into registered word writes at rising addresses
`timescale 1ns/1ps

module dma_writer #(
    parameter int DATA_WIDTH = 32,
    parameter int DEST_WIDTH = 2
) (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            enable,
    input  logic [scope_pkg::ADDR_WIDTH-1:0] base_addr,
    input  logic                            in_valid,
    input  logic [DATA_WIDTH-1:0]           in_data,
    input  logic [DEST_WIDTH-1:0]           in_dest,
    input  logic                            in_last,
    output logic                            in_ready,
    output logic                            mem_valid,
    output logic [scope_pkg::ADDR_WIDTH-1:0] mem_addr,
    output logic [DATA_WIDTH-1:0]           mem_data,
    output logic [DEST_WIDTH-1:0]           mem_dest,
    input  logic                            mem_ready,
    output logic                            dma_done,
    output logic                            frame_done
);
    import scope_pkg::*;

    logic [ADDR_WIDTH-1:0] offset;
    logic                  mem_last;
    logic                  accept;

    // The write register refills when empty or when the memory takes its word
    assign in_ready   = enable && (!mem_valid || mem_ready);
    assign accept     = in_valid && in_ready;
    assign frame_done = accept && in_last;

    always_ff @(posedge clock) begin
        if (rst) begin
            mem_valid <= 1'b0;
            mem_last  <= 1'b0;
            offset    <= '0;
            dma_done  <= 1'b0;
        end else begin
            // Done follows the acceptance of the closing word by one cycle
            dma_done <= mem_valid && mem_ready && mem_last;
            if (accept) begin
                mem_valid <= 1'b1;
                mem_last  <= in_last;
                // Word offset restarts at the beginning of every frame
                offset    <= in_last ? '0 : offset + 1'b1;
            end else if (mem_ready) begin
                mem_valid <= 1'b0;
            end
        end
    end

    // Payload with its byte address, four bytes per word
    always_ff @(posedge clock) begin
        if (accept) begin
            mem_addr <= base_addr + {offset[ADDR_WIDTH-3:0], 2'b00};
            mem_data <= in_data;
            mem_dest <= in_dest;
        end
    end

endmodule

// ==== rtl/frame_marker.sv ====
// Frame marker that counts accepted samples and flags the last one of each frame
`timescale 1ns/1ps

module frame_marker #(
    parameter int DATA_WIDTH = 32,
    parameter int DEST_WIDTH = 2
) (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic [scope_pkg::FRAME_COUNT_WIDTH-1:0] frame_len,
    input  logic                                   in_valid,
    input  logic [DATA_WIDTH-1:0]                  in_data,
    input  logic [DEST_WIDTH-1:0]                  in_dest,
    output logic                                   in_ready,
    output logic                                   out_valid,
    output logic [DATA_WIDTH-1:0]                  out_data,
    output logic [DEST_WIDTH-1:0]                  out_dest,
    output logic                                   out_last,
    input  logic                                   out_ready,
    output logic [scope_pkg::FRAME_COUNT_WIDTH-1:0] sample_count
);
    import scope_pkg::*;

    logic [FRAME_COUNT_WIDTH-1:0] count;
    logic [FRAME_COUNT_WIDTH-1:0] last_idx;

    // Pure pass-through of the handshake and payload
    assign out_valid = in_valid;
    assign out_data  = in_data;
    assign out_dest  = in_dest;
    assign in_ready  = out_ready;

    // A zero frame length behaves like a frame of one sample
    assign last_idx = (frame_len == '0) ? '0 : frame_len - 1'b1;
    assign out_last = (count == last_idx);

    assign sample_count = count;

    always_ff @(posedge clock) begin
        if (rst) begin
            count <= '0;
        end else if (in_valid && out_ready) begin
            count <= out_last ? '0 : count + 1'b1;
        end
    end

endmodule

// ==== rtl/scope_capture.sv ====
// Scope capture top level joining registers, merge, framing, trigger and DMA writer
`timescale 1ns/1ps

module scope_capture #(
    parameter int N_STREAMS  = 4,
    parameter int DATA_WIDTH = 32,
    parameter int DEST_WIDTH = 2,
    parameter int N_TRIGGERS = 8
) (
    input  logic                            clock,
    input  logic                            rst,
    input  logic [scope_pkg::ADDR_WIDTH-1:0] paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [scope_pkg::REG_WIDTH-1:0]  pwdata,
    output logic [scope_pkg::REG_WIDTH-1:0]  prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  logic [N_STREAMS-1:0]            in_valid,
    input  logic [N_STREAMS*DATA_WIDTH-1:0] in_data,
    output logic [N_STREAMS-1:0]            in_ready,
    output logic                            mem_valid,
    output logic [scope_pkg::ADDR_WIDTH-1:0] mem_addr,
    output logic [DATA_WIDTH-1:0]           mem_data,
    output logic [DEST_WIDTH-1:0]           mem_dest,
    input  logic                            mem_ready,
    output logic [N_TRIGGERS-1:0]           trigger_out,
    output logic                            dma_done
);
    import scope_pkg::*;

    // Configuration and status
    logic [FRAME_COUNT_WIDTH-1:0] frame_len;
    logic [FRAME_COUNT_WIDTH-1:0] trigger_pos;
    logic [FRAME_COUNT_WIDTH-1:0] sample_count;
    logic [REG_WIDTH-1:0]         trigger_sel;
    logic [ADDR_WIDTH-1:0]        base_addr;
    logic                         enable;
    logic                         arm;
    logic                         capture_ack;
    logic                         capture_inhibit;
    logic                         armed;
    logic                         frame_done;

    // Channel valids after the inhibit gate
    logic [N_STREAMS-1:0]  chan_valid;

    // Merged stream before and after the inhibit gate
    logic                  comb_valid;
    logic                  comb_ready;
    logic [DATA_WIDTH-1:0] comb_data;
    logic [DEST_WIDTH-1:0] comb_dest;
    logic                  gated_valid;
    logic                  gated_ready;

    // Framed stream into the DMA writer
    logic                  fr_valid;
    logic                  fr_ready;
    logic                  fr_last;
    logic [DATA_WIDTH-1:0] fr_data;
    logic [DEST_WIDTH-1:0] fr_dest;

    scope_regs regs_i (
        .clock(clock), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .sample_count(sample_count), .inhibit(capture_inhibit), .armed(armed),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .frame_len(frame_len), .enable(enable), .base_addr(base_addr),
        .trigger_sel(trigger_sel), .trigger_pos(trigger_pos),
        .arm(arm), .capture_ack(capture_ack)
    );

    // While inhibited no channel wins a grant, so every source keeps its sample
    assign chan_valid = in_valid & {N_STREAMS{!capture_inhibit}};

    stream_combiner #(
        .N_STREAMS(N_STREAMS), .DATA_WIDTH(DATA_WIDTH), .DEST_WIDTH(DEST_WIDTH)
    ) combiner_i (
        .clock(clock), .rst(rst),
        .in_valid(chan_valid), .in_data(in_data), .in_ready(in_ready),
        .out_valid(comb_valid), .out_data(comb_data), .out_dest(comb_dest),
        .out_ready(comb_ready)
    );

    // Inhibit gate; ready is held off too so the held sample is kept, not dropped
    assign gated_valid = comb_valid && !capture_inhibit;
    assign comb_ready  = gated_ready && !capture_inhibit;

    frame_marker #(
        .DATA_WIDTH(DATA_WIDTH), .DEST_WIDTH(DEST_WIDTH)
    ) marker_i (
        .clock(clock), .rst(rst), .frame_len(frame_len),
        .in_valid(gated_valid), .in_data(comb_data), .in_dest(comb_dest),
        .in_ready(gated_ready),
        .out_valid(fr_valid), .out_data(fr_data), .out_dest(fr_dest),
        .out_last(fr_last), .out_ready(fr_ready), .sample_count(sample_count)
    );

    trigger_hub #(
        .N_TRIGGERS(N_TRIGGERS)
    ) trigger_i (
        .clock(clock), .rst(rst), .arm(arm),
        .trigger_sel(trigger_sel), .trigger_pos(trigger_pos),
        .sample_count(sample_count), .frame_done(frame_done),
        .capture_ack(capture_ack), .trigger_out(trigger_out),
        .capture_inhibit(capture_inhibit), .armed(armed)
    );

    dma_writer #(
        .DATA_WIDTH(DATA_WIDTH), .DEST_WIDTH(DEST_WIDTH)
    ) dma_i (
        .clock(clock), .rst(rst), .enable(enable), .base_addr(base_addr),
        .in_valid(fr_valid), .in_data(fr_data), .in_dest(fr_dest),
        .in_last(fr_last), .in_ready(fr_ready),
        .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_data(mem_data),
        .mem_dest(mem_dest), .mem_ready(mem_ready),
        .dma_done(dma_done), .frame_done(frame_done)
    );

endmodule

// ==== rtl/scope_regs.sv ====
// APB register slave for the scope configuration, strobes and status readback
`timescale 1ns/1ps

module scope_regs (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic [scope_pkg::ADDR_WIDTH-1:0]        paddr,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [scope_pkg::REG_WIDTH-1:0]         pwdata,
    input  logic [scope_pkg::FRAME_COUNT_WIDTH-1:0] sample_count,
    input  logic                                   inhibit,
    input  logic                                   armed,
    output logic [scope_pkg::REG_WIDTH-1:0]         prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    output logic [scope_pkg::FRAME_COUNT_WIDTH-1:0] frame_len,
    output logic                                   enable,
    output logic [scope_pkg::ADDR_WIDTH-1:0]        base_addr,
    output logic [scope_pkg::REG_WIDTH-1:0]         trigger_sel,
    output logic [scope_pkg::FRAME_COUNT_WIDTH-1:0] trigger_pos,
    output logic                                   arm,
    output logic                                   capture_ack
);
    import scope_pkg::*;

    logic                 access;
    logic                 wr_en;
    logic                 mapped;
    logic [REG_WIDTH-1:0] rd_data;

    // Access phase of an APB transfer, never stretched since pready stays high
    assign access = psel && penable;
    assign wr_en  = access && pwrite;
    assign pready = 1'b1;

    // Address decode and read multiplexer
    always_comb begin
        mapped  = 1'b1;
        rd_data = '0;
        case (paddr)
            REG_FRAME_LEN:   rd_data = {{(REG_WIDTH-FRAME_COUNT_WIDTH){1'b0}}, frame_len};
            REG_ENABLE:      rd_data = {{(REG_WIDTH-1){1'b0}}, enable};
            REG_BASE_ADDR:   rd_data = base_addr;
            REG_TRIGGER_SEL: rd_data = trigger_sel;
            REG_CAPTURE_ACK: rd_data = '0;
            REG_TRIGGER_POS: rd_data = {{(REG_WIDTH-FRAME_COUNT_WIDTH){1'b0}}, trigger_pos};
            // Status packs the flags right above the sample count
            REG_STATUS: begin
                rd_data = {{(REG_WIDTH-FRAME_COUNT_WIDTH-2){1'b0}}, armed, inhibit,
                           sample_count};
            end
            default:         mapped = 1'b0;
        endcase
    end

    // Read data is only driven during a read, an unmapped access flags an error
    assign prdata  = (psel && !pwrite) ? rd_data : '0;
    assign pslverr = access && !mapped;

    // Configuration registers load on the access phase edge
    always_ff @(posedge clock) begin
        if (rst) begin
            frame_len   <= '0;
            enable      <= 1'b0;
            base_addr   <= '0;
            trigger_sel <= '0;
            trigger_pos <= '0;
            arm         <= 1'b0;
            capture_ack <= 1'b0;
        end else begin
            // Strobes last exactly one cycle
            arm         <= wr_en && (paddr == REG_TRIGGER_SEL);
            capture_ack <= wr_en && (paddr == REG_CAPTURE_ACK) && pwdata[0];
            if (wr_en) begin
                case (paddr)
                    REG_FRAME_LEN:   frame_len   <= pwdata[FRAME_COUNT_WIDTH-1:0];
                    REG_ENABLE:      enable      <= pwdata[0];
                    REG_BASE_ADDR:   base_addr   <= pwdata;
                    REG_TRIGGER_SEL: trigger_sel <= pwdata;
                    REG_TRIGGER_POS: trigger_pos <= pwdata[FRAME_COUNT_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== rtl/stream_combiner.sv ====
// Round-robin merge of the channel streams into one registered, tagged stream
`timescale 1ns/1ps

module stream_combiner #(
    parameter int N_STREAMS  = 4,
    parameter int DATA_WIDTH = 32,
    parameter int DEST_WIDTH = 2
) (
    input  logic                            clock,
    input  logic                            rst,
    input  logic [N_STREAMS-1:0]            in_valid,
    input  logic [N_STREAMS*DATA_WIDTH-1:0] in_data,
    output logic [N_STREAMS-1:0]            in_ready,
    output logic                            out_valid,
    output logic [DATA_WIDTH-1:0]           out_data,
    output logic [DEST_WIDTH-1:0]           out_dest,
    input  logic                            out_ready
);

    logic [DEST_WIDTH-1:0] last_grant;
    logic [DEST_WIDTH-1:0] grant_idx;
    logic                  grant_found;
    logic                  load;
    int unsigned           cand;

    // The output register can take a sample when empty or emptying this cycle
    assign load = !out_valid || out_ready;

    // Search starts one past the last winner and wraps around once
    always_comb begin
        grant_found = 1'b0;
        grant_idx   = '0;
        cand        = 0;
        for (int i = 1; i <= N_STREAMS; i++) begin
            cand = (int'(last_grant) + i) % N_STREAMS;
            if (!grant_found && in_valid[cand]) begin
                grant_found = 1'b1;
                grant_idx   = DEST_WIDTH'(cand);
            end
        end
    end

    // Only the winner sees ready
    always_comb begin
        in_ready = '0;
        if (grant_found && load) begin
            in_ready[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            out_valid  <= 1'b0;
            // First search after reset begins at channel 0
            last_grant <= DEST_WIDTH'(N_STREAMS - 1);
        end else if (load) begin
            out_valid <= grant_found;
            if (grant_found) begin
                last_grant <= grant_idx;
            end
        end
    end

    // Payload and tag of the granted channel
    always_ff @(posedge clock) begin
        if (load && grant_found) begin
            out_data <= in_data[grant_idx*DATA_WIDTH +: DATA_WIDTH];
            out_dest <= grant_idx;
        end
    end

endmodule

// ==== rtl/trigger_hub.sv ====
// Trigger hub FSM that fires one selected line and inhibits capture until acknowledged
`timescale 1ns/1ps

module trigger_hub #(
    parameter int N_TRIGGERS = 8
) (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic                                   arm,
    input  logic [scope_pkg::REG_WIDTH-1:0]         trigger_sel,
    input  logic [scope_pkg::FRAME_COUNT_WIDTH-1:0] trigger_pos,
    input  logic [scope_pkg::FRAME_COUNT_WIDTH-1:0] sample_count,
    input  logic                                   frame_done,
    input  logic                                   capture_ack,
    output logic [N_TRIGGERS-1:0]                  trigger_out,
    output logic                                   capture_inhibit,
    output logic                                   armed
);
    import scope_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARMED,
        ST_FIRED,
        ST_INHIBITED
    } state_t;

    state_t               state;
    logic [REG_WIDTH-1:0] sel_idx;
    logic                 hit;

    // Out of range selections wrap onto the available lines
    assign sel_idx = trigger_sel % REG_WIDTH'(N_TRIGGERS);
    assign hit     = (sample_count == trigger_pos);

    assign armed           = (state == ST_ARMED);
    assign capture_inhibit = (state == ST_INHIBITED);

    always_ff @(posedge clock) begin
        if (rst) begin
            state       <= ST_IDLE;
            trigger_out <= '0;
        end else begin
            trigger_out <= '0;
            case (state)
                ST_IDLE: if (arm) state <= ST_ARMED;
                ST_ARMED: begin
                    if (hit) begin
                        trigger_out[sel_idx] <= 1'b1;
                        // When the trigger sample closes the frame, skip straight ahead
                        state <= frame_done ? ST_INHIBITED : ST_FIRED;
                    end
                end
                // Wait for the frame holding the trigger to finish
                ST_FIRED: if (frame_done) state <= ST_INHIBITED;
                ST_INHIBITED: if (capture_ack) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== test/scope_capture_props.sv ====
// Bound protocol checks on the memory port, trigger lines, APB ready and inhibit gate
`timescale 1ns/1ps

module scope_capture_props #(
    parameter int N_STREAMS  = 4,
    parameter int DATA_WIDTH = 32,
    parameter int N_TRIGGERS = 8
) (
    input logic                             clock,
    input logic                             rst,
    input logic                             mem_valid,
    input logic                             mem_ready,
    input logic [scope_pkg::ADDR_WIDTH-1:0] mem_addr,
    input logic [DATA_WIDTH-1:0]            mem_data,
    input logic [N_TRIGGERS-1:0]            trigger_out,
    input logic                             pready,
    input logic [N_STREAMS-1:0]             in_ready,
    input logic                             capture_inhibit,
    input logic [N_STREAMS-1:0]             in_valid
);

    // Running total of failed properties
    int fail_count = 0;

    // A stalled memory write keeps its address and data
    mem_hold: assert property (@(posedge clock) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_data))
    else begin
        $error("memory write changed while stalled");
        fail_count++;
    end

    // Only one trigger line pulses at a time
    one_trigger: assert property (@(posedge clock) disable iff (rst) $onehot0(trigger_out))
    else begin
        $error("more than one trigger line high");
        fail_count++;
    end

    // The register slave never inserts wait states
    no_wait: assert property (@(posedge clock) disable iff (rst) pready)
    else begin
        $error("pready dropped");
        fail_count++;
    end

    // While inhibited no offering channel sees ready
    inhibit_gate: assert property (@(posedge clock) disable iff (rst)
        capture_inhibit |-> ((in_ready & in_valid) == '0))
    else begin
        $error("channel ready while inhibited and offering a sample");
        fail_count++;
    end

endmodule

bind scope_capture scope_capture_props #(
    .N_STREAMS(N_STREAMS), .DATA_WIDTH(DATA_WIDTH), .N_TRIGGERS(N_TRIGGERS)
) props_i (
    .clock(clock), .rst(rst),
    .mem_valid(mem_valid), .mem_ready(mem_ready),
    .mem_addr(mem_addr), .mem_data(mem_data),
    .trigger_out(trigger_out), .pready(pready), .in_ready(in_ready),
    .capture_inhibit(capture_inhibit), .in_valid(in_valid)
);

// ==== test/scope_capture_tb.sv ====
// Testbench for the scope capture subsystem running table rows over APB, channels and memory
`timescale 1ns/1ps

module scope_capture_tb;
    import scope_pkg::*;

    localparam int N_STREAMS  = 4;
    localparam int DATA_WIDTH = 32;
    localparam int DEST_WIDTH = 2;
    localparam int N_TRIGGERS = 8;
    localparam int N_ROWS     = 4;
    localparam int TIMEOUT    = 5000;
    localparam int HOLD       = 30;

    // One capture run with frame length, base address, trigger line and position,
    // samples per channel and memory back-pressure
    typedef struct {
        int          frame_len;
        logic [31:0] base;
        int          sel;
        int          pos;
        int          per_ch;
        bit          bp;
    } row_t;

    // Every run spans whole frames and more than one frame
    row_t rows [N_ROWS] = '{
        '{8, 32'h0000_1000, 3, 2, 4, 1'b0},
        '{6, 32'h0000_2040, 10, 5, 6, 1'b1},
        '{4, 32'h8000_0000, 7, 0, 3, 1'b1},
        '{5, 32'h0000_0100, 0, 4, 5, 1'b1}
    };

    logic                            clock = 1'b0;
    logic                            rst = 1'b1;
    logic [ADDR_WIDTH-1:0]           paddr = '0;
    logic                            psel = 1'b0;
    logic                            penable = 1'b0;
    logic                            pwrite = 1'b0;
    logic [REG_WIDTH-1:0]            pwdata = '0;
    logic [REG_WIDTH-1:0]            prdata;
    logic                            pready;
    logic                            pslverr;
    logic [N_STREAMS-1:0]            in_valid = '0;
    logic [N_STREAMS*DATA_WIDTH-1:0] in_data = '0;
    logic [N_STREAMS-1:0]            in_ready;
    logic                            mem_valid;
    logic [ADDR_WIDTH-1:0]           mem_addr;
    logic [DATA_WIDTH-1:0]           mem_data;
    logic [DEST_WIDTH-1:0]           mem_dest;
    logic                            mem_ready = 1'b0;
    logic [N_TRIGGERS-1:0]           trigger_out;
    logic                            dma_done;

    // Reference model with one queue per channel and the expected word index
    logic [DATA_WIDTH-1:0] exp_q [N_STREAMS][$];
    int                    sent [N_STREAMS] = '{default: 0};
    int                    pulses [N_TRIGGERS] = '{default: 0};
    int                    exp_word = 0;
    int                    mem_writes = 0;
    int                    writes_base = 0;
    int                    done_count = 0;
    int                    errors = 0;
    int                    checks = 0;
    int                    row_idx = 0;
    bit                    running = 1'b0;
    logic [31:0]           lfsr = 32'heaf0;
    row_t                  cur;

    always #4 clock = ~clock;

    scope_capture #(
        .N_STREAMS(N_STREAMS), .DATA_WIDTH(DATA_WIDTH),
        .DEST_WIDTH(DEST_WIDTH), .N_TRIGGERS(N_TRIGGERS)
    ) scope_capture_i (
        .clock(clock), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_data(mem_data),
        .mem_dest(mem_dest), .mem_ready(mem_ready),
        .trigger_out(trigger_out), .dma_done(dma_done)
    );

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
    function automatic bit next_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: %s", what);
        $display("STATUS: FAIL");
        $finish;
    endtask

    // Setup phase, then access phase until pready completes the transfer
    task automatic apb_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic write, output logic [31:0] rdata,
                              output logic err);
        int waited;
        waited = 0;
        @(posedge clock);
        paddr   <= addr;
        pwdata  <= wdata;
        pwrite  <= write;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clock);
        penable <= 1'b1;
        @(posedge clock);
        while (!pready) begin
            waited++;
            if (waited > TIMEOUT) begin
                timeout_fail("APB access never completed");
            end
            @(posedge clock);
        end
        rdata   = prdata;
        err     = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, data, 1'b1, rdata, err);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata,
                            output logic err);
        apb_access(addr, '0, 1'b0, rdata, err);
    endtask

    task automatic write_and_verify(input logic [31:0] addr, input logic [31:0] data,
                                    input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        apb_write(addr, data);
        apb_read(addr, rdata, err);
        check(err, 0, "pslverr on a mapped register");
        check(rdata, expected, $sformatf("readback of register %0h", addr));
    endtask

    // Channel sources and memory ready, driven on the rising edge
    always @(posedge clock) begin
        logic [DATA_WIDTH-1:0] word;
        if (rst || !running) begin
            in_valid  <= '0;
            mem_ready <= 1'b0;
            for (int c = 0; c < N_STREAMS; c++) begin
                sent[c] = 0;
            end
        end else begin
            mem_ready <= cur.bp ? next_bit() : 1'b1;
            for (int c = 0; c < N_STREAMS; c++) begin
                // A source holds its sample until the handshake, then may leave a gap
                if (!in_valid[c] || in_ready[c]) begin
                    if (sent[c] < cur.per_ch && next_bit()) begin
                        word = {8'(c), 8'(row_idx), 16'(sent[c])};
                        exp_q[c].push_back(word);
                        in_data[c*DATA_WIDTH +: DATA_WIDTH] <= word;
                        in_valid[c] <= 1'b1;
                        sent[c]++;
                    end else begin
                        in_valid[c] <= 1'b0;
                    end
                end
            end
        end
    end

    // Memory side compare, frame bookkeeping and trigger pulse counting
    always @(posedge clock) begin
        if (!rst) begin
            for (int b = 0; b < N_TRIGGERS; b++) begin
                if (trigger_out[b]) begin
                    pulses[b]++;
                    // Pulse lands within one word of the trigger sample reaching memory
                    if (b == cur.sel % N_TRIGGERS) begin
                        check(mem_writes - writes_base >= cur.pos - 1 &&
                              mem_writes - writes_base <= cur.pos + 1, 1, "trigger position");
                    end
                end
            end
            if (mem_valid && mem_ready) begin
                mem_writes++;
                check(exp_q[mem_dest].size() != 0, 1, "write matches a driven sample");
                if (exp_q[mem_dest].size() != 0) begin
                    check(mem_data, exp_q[mem_dest].pop_front(), "mem_data in channel order");
                end
                check(mem_addr, cur.base + 32'(4 * exp_word), "mem_addr");
                exp_word = (exp_word + 1 == cur.frame_len) ? 0 : exp_word + 1;
            end
            if (dma_done) begin
                done_count++;
            end
        end
    end

    initial begin
        logic [31:0] rdata;
        logic        err;
        int          waited;
        int          inhibit_writes;
        int          done_at;
        int          errors_at;
        int          total;
        int          pulses_at [N_TRIGGERS];

        repeat (10) @(posedge clock);
        rst <= 1'b0;

        // Unmapped address answers with an error and reads as zero
        apb_read(32'h0000_001C, rdata, err);
        check(err, 1, "pslverr on unmapped read");
        check(rdata, 0, "unmapped read data");

        for (int r = 0; r < N_ROWS; r++) begin
            cur         = rows[r];
            row_idx     = r;
            total       = cur.per_ch * N_STREAMS;
            errors_at   = errors;
            writes_base = mem_writes;
            done_at     = done_count;
            pulses_at   = pulses;
            write_and_verify(REG_ENABLE, 32'h0, 32'h0);
            write_and_verify(REG_FRAME_LEN, cur.frame_len, cur.frame_len);
            write_and_verify(REG_BASE_ADDR, cur.base, cur.base);
            write_and_verify(REG_TRIGGER_POS, cur.pos, cur.pos);
            // Selecting the trigger line also arms the hub
            write_and_verify(REG_TRIGGER_SEL, cur.sel, cur.sel);

            // Sources offer data while the writer is still disabled
            @(negedge clock);
            running = 1'b1;
            repeat (HOLD) @(negedge clock);
            check(mem_writes - writes_base, 0, "no writes while disabled");
            apb_write(REG_ENABLE, 32'h1);

            // The frame holding the trigger closes and capture stops
            waited = 0;
            while (done_count == done_at) begin
                @(negedge clock);
                waited++;
                if (waited > TIMEOUT) begin
                    timeout_fail("no dma_done for the triggered frame");
                end
            end
            inhibit_writes = mem_writes;
            repeat (HOLD) @(negedge clock);
            check(mem_writes, inhibit_writes, "no writes while inhibited");
            apb_read(REG_STATUS, rdata, err);
            check(rdata, 32'h0001_0000, "status with inhibit set");
            write_and_verify(REG_CAPTURE_ACK, 32'h1, 32'h0);

            // After the acknowledge the rest of the samples drain to memory
            waited = 0;
            while (mem_writes - writes_base < total) begin
                @(negedge clock);
                waited++;
                if (waited > TIMEOUT) begin
                    timeout_fail("samples missing at the memory port");
                end
            end
            repeat (4) @(negedge clock);
            running = 1'b0;
            check(done_count - done_at, total / cur.frame_len, "dma_done pulses per frame");
            for (int c = 0; c < N_STREAMS; c++) begin
                check(exp_q[c].size(), 0, "samples left in the reference queue");
            end
            for (int b = 0; b < N_TRIGGERS; b++) begin
                check(pulses[b] - pulses_at[b], b == cur.sel % N_TRIGGERS, "trigger pulses");
            end
            $display("test %0d: %0d samples, frame length %0d, %0d errors",
                     r, total, cur.frame_len, errors - errors_at);
        end

        check(scope_capture_i.props_i.fail_count, 0, "assertion failures");
        $display("%0d tests, %0d checks, %0d errors", N_ROWS, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
